/* hdl/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    // datapath width of the rv32i core
    localparam int xlen = 32;

    // architectural register file
    localparam int num_arch_regs = 32;
    localparam int reg_addr_w = 5;

    // reorder buffer geometry, tag is the entry index
    localparam int rob_depth = 32;
    localparam int rob_idx_w = 5;
    // occupancy counter needs one extra bit to reach rob_depth
    localparam int rob_cnt_w = rob_idx_w + 1;

    // one instruction entering rename
    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd_addr;
        logic [reg_addr_w-1:0] rs1_addr;
        logic [reg_addr_w-1:0] rs2_addr;
    } dispatch_t;

    // result broadcast, tag plus value
    typedef struct packed {
        logic                 valid;
        logic [rob_idx_w-1:0] rob_idx;
        logic [xlen-1:0]      data;
    } cdb_t;

    // one in-order retirement from the head
    typedef struct packed {
        logic                  valid;
        logic [rob_idx_w-1:0]  rob_idx;
        logic [reg_addr_w-1:0] rd_addr;
        logic [xlen-1:0]       data;
    } commit_t;

    // resolved source operand
    // data valid when ready, rob_idx valid otherwise
    typedef struct packed {
        logic                 ready;
        logic [rob_idx_w-1:0] rob_idx;
        logic [xlen-1:0]      data;
    } operand_t;

    // buffer state reported for a probed tag
    typedef struct packed {
        logic            done;
        logic [xlen-1:0] data;
    } rob_status_t;

endpackage

`default_nettype wire

/* hdl/rat_arf.sv */
`timescale 1ns/100ps
`default_nettype none

module rat_arf (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              alloc,
    input  logic [rename_pkg::reg_addr_w-1:0] alloc_rd,
    input  logic [rename_pkg::rob_idx_w-1:0]  alloc_idx,
    input  rename_pkg::commit_t               commit,
    input  logic [rename_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [rename_pkg::reg_addr_w-1:0] rs2_addr,
    output rename_pkg::operand_t              rs1_entry,
    output rename_pkg::operand_t              rs2_entry
);
    import rename_pkg::*;

    // architectural values, committed state only
    logic [xlen-1:0]          value_q [num_arch_regs];
    // producer tag per register, meaningful while not ready
    logic [rob_idx_w-1:0]     tag_q   [num_arch_regs];
    logic [num_arch_regs-1:0] ready_q;

    logic rename_en;
    logic retire_en;
    logic retire_match;

    // x0 is hardwired, never renamed
    assign rename_en = alloc && (alloc_rd != '0);
    assign retire_en = commit.valid && (commit.rd_addr != '0);

    // only the latest producer of rd may release the mapping
    assign retire_match = retire_en && (tag_q[commit.rd_addr] == commit.rob_idx);

    always_ff @(posedge clk) begin
        if (rst) begin
            // all registers ready, value zero
            for (int i = 0; i < num_arch_regs; i++) begin
                value_q[i] <= '0;
                tag_q[i]   <= '0;
                ready_q[i] <= 1'b1;
            end
        end else begin
            // value always lands, even if a younger rename exists
            if (retire_en) begin
                value_q[commit.rd_addr] <= commit.data;
            end
            if (retire_match) begin
                ready_q[commit.rd_addr] <= 1'b1;
            end
            // rename last so it overrides a same-cycle retire
            if (rename_en) begin
                ready_q[alloc_rd] <= 1'b0;
                tag_q[alloc_rd]   <= alloc_idx;
            end
        end
    end

    // read ports, state before this cycle's edge
    always_comb begin
        rs1_entry.ready   = ready_q[rs1_addr];
        rs1_entry.rob_idx = tag_q[rs1_addr];
        rs1_entry.data    = value_q[rs1_addr];
        // x0 reads ready zero regardless of array contents
        if (rs1_addr == '0) begin
            rs1_entry.ready = 1'b1;
            rs1_entry.data  = '0;
        end
    end

    always_comb begin
        rs2_entry.ready   = ready_q[rs2_addr];
        rs2_entry.rob_idx = tag_q[rs2_addr];
        rs2_entry.data    = value_q[rs2_addr];
        if (rs2_addr == '0) begin
            rs2_entry.ready = 1'b1;
            rs2_entry.data  = '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/reorder_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer (
    input  logic                             clk,
    input  logic                             rst,
    input  rename_pkg::dispatch_t            dispatch,
    input  rename_pkg::cdb_t                 cdb,
    output logic                             alloc,
    output logic [rename_pkg::rob_idx_w-1:0] alloc_idx,
    output logic                             full,
    input  logic [rename_pkg::rob_idx_w-1:0] probe1_idx,
    input  logic [rename_pkg::rob_idx_w-1:0] probe2_idx,
    output rename_pkg::rob_status_t          probe1,
    output rename_pkg::rob_status_t          probe2,
    output rename_pkg::commit_t              commit
);
    import rename_pkg::*;

    // circular buffer pointers, wrap naturally at rob_depth
    logic [rob_idx_w-1:0] head_q;
    logic [rob_idx_w-1:0] tail_q;
    logic [rob_cnt_w-1:0] count_q;

    // per-entry state
    logic [rob_depth-1:0]  done_q;
    logic [reg_addr_w-1:0] rd_q   [rob_depth];
    logic [xlen-1:0]       data_q [rob_depth];

    logic retire;

    assign full = (count_q == rob_cnt_w'(rob_depth));

    // head leaves once its result is in
    assign retire = (count_q != '0) && done_q[head_q];

    // full is fine if the head frees a slot this cycle
    assign alloc     = dispatch.valid && (!full || retire);
    assign alloc_idx = tail_q;

    // retirement view of the head entry
    always_comb begin
        commit.valid   = retire;
        commit.rob_idx = head_q;
        commit.rd_addr = rd_q[head_q];
        commit.data    = data_q[head_q];
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (retire) begin
                head_q         <= head_q + 1'b1;
                done_q[head_q] <= 1'b0;
            end
            // result arrives, entry may retire next cycle
            if (cdb.valid) begin
                done_q[cdb.rob_idx] <= 1'b1;
            end
            // new entry starts not done
            if (alloc) begin
                tail_q         <= tail_q + 1'b1;
                done_q[tail_q] <= 1'b0;
            end
            case ({alloc, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // payload, written on allocate and broadcast
    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_q[tail_q] <= dispatch.rd_addr;
        end
        if (cdb.valid) begin
            data_q[cdb.rob_idx] <= cdb.data;
        end
    end

    // tag probes for operand forwarding
    always_comb begin
        probe1.done = done_q[probe1_idx];
        probe1.data = data_q[probe1_idx];
    end

    always_comb begin
        probe2.done = done_q[probe2_idx];
        probe2.data = data_q[probe2_idx];
    end

endmodule

`default_nettype wire

/* hdl/operand_lookup.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_lookup (
    input  rename_pkg::operand_t             rs1_entry,
    input  rename_pkg::operand_t             rs2_entry,
    output logic [rename_pkg::rob_idx_w-1:0] probe1_idx,
    output logic [rename_pkg::rob_idx_w-1:0] probe2_idx,
    input  rename_pkg::rob_status_t          probe1,
    input  rename_pkg::rob_status_t          probe2,
    output rename_pkg::operand_t             rs1_operand,
    output rename_pkg::operand_t             rs2_operand
);
    import rename_pkg::*;

    // three outcomes per source
    // ready from the arf, forwarded from a done entry, or wait on tag
    function automatic operand_t resolve(input operand_t entry, input rob_status_t status);
        operand_t res;
        res = entry;
        if (!entry.ready) begin
            if (status.done) begin
                // finished but not yet retired
                res.ready = 1'b1;
                res.data  = status.data;
            end else begin
                // still in flight, data has no meaning
                res.ready = 1'b0;
                res.data  = '0;
            end
        end
        return res;
    endfunction

    // probe with the mapped tag
    // result ignored when the register is already ready
    assign probe1_idx = rs1_entry.rob_idx;
    assign probe2_idx = rs2_entry.rob_idx;

    always_comb begin
        rs1_operand = resolve(rs1_entry, probe1);
    end

    always_comb begin
        rs2_operand = resolve(rs2_entry, probe2);
    end

endmodule

`default_nettype wire

/* hdl/rename_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_core (
    input  logic                             clk,
    input  logic                             rst,
    input  rename_pkg::dispatch_t            dispatch,
    input  rename_pkg::cdb_t                 cdb,
    output logic [rename_pkg::rob_idx_w-1:0] alloc_idx,
    output logic                             rob_full,
    output rename_pkg::operand_t             rs1_operand,
    output rename_pkg::operand_t             rs2_operand,
    output rename_pkg::commit_t              commit
);
    import rename_pkg::*;

    // accepted dispatch strobe
    logic alloc;

    // register file read ports
    operand_t rs1_entry;
    operand_t rs2_entry;

    // forwarding probes into the buffer
    logic [rob_idx_w-1:0] probe1_idx;
    logic [rob_idx_w-1:0] probe2_idx;
    rob_status_t          probe1;
    rob_status_t          probe2;

    rat_arf u_rat_arf (
        .clk       (clk),
        .rst       (rst),
        .alloc     (alloc),
        .alloc_rd  (dispatch.rd_addr),
        .alloc_idx (alloc_idx),
        .commit    (commit),
        .rs1_addr  (dispatch.rs1_addr),
        .rs2_addr  (dispatch.rs2_addr),
        .rs1_entry (rs1_entry),
        .rs2_entry (rs2_entry)
    );

    reorder_buffer u_rob (
        .clk        (clk),
        .rst        (rst),
        .dispatch   (dispatch),
        .cdb        (cdb),
        .alloc      (alloc),
        .alloc_idx  (alloc_idx),
        .full       (rob_full),
        .probe1_idx (probe1_idx),
        .probe2_idx (probe2_idx),
        .probe1     (probe1),
        .probe2     (probe2),
        .commit     (commit)
    );

    // same-cycle operand resolution
    operand_lookup u_operand_lookup (
        .rs1_entry   (rs1_entry),
        .rs2_entry   (rs2_entry),
        .probe1_idx  (probe1_idx),
        .probe2_idx  (probe2_idx),
        .probe1      (probe1),
        .probe2      (probe2),
        .rs1_operand (rs1_operand),
        .rs2_operand (rs2_operand)
    );

endmodule

`default_nettype wire

/* tb/rename_core_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_core_chk (
    input logic                             clk,
    input logic                             rst,
    input logic                             cdb_valid,
    input logic [rename_pkg::rob_idx_w-1:0] cdb_idx,
    input logic                             alloc,
    input logic [rename_pkg::rob_idx_w-1:0] alloc_idx,
    input logic                             full,
    input logic [rename_pkg::rob_idx_w-1:0] head_q,
    input logic [rename_pkg::rob_cnt_w-1:0] count_q,
    input logic [rename_pkg::rob_depth-1:0] done_q,
    input rename_pkg::commit_t              commit
);
    import rename_pkg::*;

    // occupancy drops by one only when nothing enters
    a_full_count: assert property (@(posedge clk) disable iff (rst)
        (full && commit.valid) |=> (count_q == ($past(alloc) ? rob_cnt_w'(rob_depth)
                                                               : rob_cnt_w'(rob_depth - 1))))
        else $error("buffer occupancy wrong after retiring from full");

    // a retirement takes the head, moves it by one and uses up its done bit
    a_commit_head: assert property (@(posedge clk) disable iff (rst)
        commit.valid |=> ((head_q == $past(head_q) + 1'b1) &&
                          (!done_q[$past(head_q)] || $past(cdb_valid && cdb_idx == head_q))))
        else $error("retirement did not advance the head or left its entry done");

    // tags handed out in sequence, wrapping at depth
    a_alloc_step: assert property (@(posedge clk) disable iff (rst)
        alloc |=> (alloc_idx == $past(alloc_idx) + 1'b1))
        else $error("alloc_idx did not advance after an accepted dispatch");

    a_alloc_hold: assert property (@(posedge clk) disable iff (rst)
        !alloc |=> (alloc_idx == $past(alloc_idx)))
        else $error("alloc_idx moved without an accepted dispatch");

endmodule

bind reorder_buffer rename_core_chk chk0 (
    .clk       (clk),
    .rst       (rst),
    .cdb_valid (cdb.valid),
    .cdb_idx   (cdb.rob_idx),
    .alloc     (alloc),
    .alloc_idx (alloc_idx),
    .full      (full),
    .head_q    (head_q),
    .count_q   (count_q),
    .done_q    (done_q),
    .commit    (commit)
);

`default_nettype wire

/* tb/rename_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_core_tb;
    import rename_pkg::*;

    localparam string case_file = "tb/rename_cases.txt";

    logic      clk = 1'b0;
    logic      rst;
    dispatch_t dispatch;
    cdb_t      cdb;

    logic [rob_idx_w-1:0] alloc_idx;
    logic                 rob_full;
    operand_t             rs1_operand;
    operand_t             rs2_operand;
    commit_t              commit;

    // buffer occupancy model, state after the last edge
    int                   m_count;
    logic [rob_idx_w-1:0] m_head;
    logic [rob_idx_w-1:0] m_tail;
    logic [rob_depth-1:0] m_done;

    string   lines_q [$];
    commit_t expect_q [$];
    commit_t got_q [$];

    int checks;
    int errors;
    int cycles;
    int cycle_limit;

    rename_core dut0 (
        .clk         (clk),
        .rst         (rst),
        .dispatch    (dispatch),
        .cdb         (cdb),
        .alloc_idx   (alloc_idx),
        .rob_full    (rob_full),
        .rs1_operand (rs1_operand),
        .rs2_operand (rs2_operand),
        .commit      (commit)
    );

    always #10 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the case steps did not complete", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic read_cases();
        int    fd;
        string line;
        fd = $fopen(case_file, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the case file %s", case_file);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0) begin
                    // skip comments and blank lines
                    if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                        lines_q.push_back(line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_operand(input string name, input operand_t got, input int exp_ready,
                                 input int exp_tag, input logic [xlen-1:0] exp_data);
        checks++;
        if (got.ready !== exp_ready[0]) begin
            errors++;
            $display("MISMATCH t=%0t %s ready expected %0d got %0b",
                     $time, name, exp_ready, got.ready);
        end else if (exp_ready != 0 && got.data !== exp_data) begin
            errors++;
            $display("MISMATCH t=%0t %s data expected %h got %h", $time, name, exp_data, got.data);
        end else if (exp_ready == 0 && got.rob_idx !== rob_idx_w'(exp_tag)) begin
            errors++;
            $display("MISMATCH t=%0t %s tag expected %0d got %0d",
                     $time, name, exp_tag, got.rob_idx);
        end
    endtask

    // drive at the falling edge, check once settled
    task automatic apply(input dispatch_t d, input cdb_t c);
        dispatch = d;
        cdb      = c;
        #5;
        checks++;
        if (rob_full !== (m_count == rob_depth)) begin
            errors++;
            $display("MISMATCH t=%0t rob_full expected %0b got %0b",
                     $time, (m_count == rob_depth), rob_full);
        end
        if (d.valid) begin
            checks++;
            if (alloc_idx !== m_tail) begin
                errors++;
                $display("MISMATCH t=%0t alloc_idx expected %0d got %0d", $time, m_tail, alloc_idx);
            end
        end
    endtask

    // model the coming edge, then move to the next falling edge
    task automatic advance();
        logic retire;
        logic accept;
        // this cycle's retirement, taken by the coming edge
        if (commit.valid) begin
            got_q.push_back(commit);
        end
        retire = (m_count != 0) && m_done[m_head];
        // under full only a leaving head makes room
        accept = dispatch.valid && ((m_count < rob_depth) || retire);
        if (retire) begin
            m_done[m_head] = 1'b0;
            m_head         = m_head + 1'b1;
        end
        if (cdb.valid) begin
            m_done[cdb.rob_idx] = 1'b1;
        end
        if (accept) begin
            m_done[m_tail] = 1'b0;
            m_tail         = m_tail + 1'b1;
        end
        m_count = m_count + (accept ? 1 : 0) - (retire ? 1 : 0);
        @(negedge clk);
    endtask

    task automatic idle_cycle();
        apply('0, '0);
        advance();
    endtask

    task automatic process_line(input string line);
        string       kind;
        int          n;
        int          cnt;
        int          rd;
        int          rs1;
        int          rs2;
        int          r1;
        int          t1;
        int          r2;
        int          t2;
        int          tag;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] data;
        dispatch_t   d;
        cdb_t        c;
        commit_t     e;
        n = $sscanf(line, "%s", kind);
        if (kind == "D") begin
            n = $sscanf(line, "%s %d %d %d %d %d %d %h %d %d %h",
                        kind, cnt, rd, rs1, rs2, r1, t1, v1, r2, t2, v2);
            if (n != 11) begin
                errors++;
                $display("unreadable dispatch line in the case file: %s", line);
            end else begin
                for (int i = 0; i < cnt; i++) begin
                    d.valid    = 1'b1;
                    d.rd_addr  = reg_addr_w'(rd);
                    d.rs1_addr = reg_addr_w'(rs1);
                    d.rs2_addr = reg_addr_w'(rs2);
                    apply(d, '0);
                    check_operand("rs1", rs1_operand, r1, t1, v1);
                    check_operand("rs2", rs2_operand, r2, t2, v2);
                    advance();
                end
            end
        end else if (kind == "B") begin
            n = $sscanf(line, "%s %d %h", kind, tag, data);
            c.valid   = 1'b1;
            c.rob_idx = rob_idx_w'(tag);
            c.data    = data;
            apply('0, c);
            advance();
        end else if (kind == "R") begin
            n = $sscanf(line, "%s %d %d %h", kind, tag, rd, data);
            e.valid   = 1'b1;
            e.rob_idx = rob_idx_w'(tag);
            e.rd_addr = reg_addr_w'(rd);
            e.data    = data;
            expect_q.push_back(e);
            idle_cycle();
        end else if (kind == "I") begin
            idle_cycle();
        end else begin
            errors++;
            $display("unknown step in the case file: %s", line);
        end
    endtask

    // retirement order only, cycle is free
    task automatic compare_retirements();
        checks++;
        if (got_q.size() != expect_q.size()) begin
            errors++;
            $display("MISMATCH t=%0t retirement count expected %0d got %0d",
                     $time, expect_q.size(), got_q.size());
        end
        for (int i = 0; i < expect_q.size() && i < got_q.size(); i++) begin
            checks++;
            if (got_q[i].rob_idx !== expect_q[i].rob_idx ||
                got_q[i].rd_addr !== expect_q[i].rd_addr ||
                got_q[i].data !== expect_q[i].data) begin
                errors++;
                $display("MISMATCH t=%0t retirement %0d expected %0d/%0d/%h got %0d/%0d/%h",
                         $time, i, expect_q[i].rob_idx, expect_q[i].rd_addr, expect_q[i].data,
                         got_q[i].rob_idx, got_q[i].rd_addr, got_q[i].data);
            end
        end
    endtask

    initial begin
        rst         = 1'b1;
        dispatch    = '0;
        cdb         = '0;
        checks      = 0;
        errors      = 0;
        cycles      = 0;
        cycle_limit = 100;
        m_count     = 0;
        m_head      = '0;
        m_tail      = '0;
        m_done      = '0;
        void'($urandom(32'h65ca));
        read_cases();
        cycle_limit = 40 * lines_q.size() + 100;
        // two reset edges
        repeat (2) @(negedge clk);
        rst = 1'b0;
        foreach (lines_q[i]) begin
            process_line(lines_q[i]);
            repeat ($urandom % 3) idle_cycle();
        end
        // late retirements still to come
        while (got_q.size() < expect_q.size()) begin
            idle_cycle();
        end
        compare_retirements();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/rename_cases.txt */
# D n rd rs1 rs2 rdy1 tag1 val1 rdy2 tag2 val2 is a dispatch repeated n times with expected operands
# B tag data is a broadcast, I is an idle cycle, R tag rd data is idle with the next retirement
# after reset, rd 0 never waits
D 1 0 31 7 1 0 00000000 1 0 00000000
D 1 0 0 0 1 0 00000000 1 0 00000000
B 0 00000011
B 1 00000022
R 0 0 00000011
R 1 0 00000022
# dependent chain, out of order results
D 1 3 0 0 1 0 00000000 1 0 00000000
D 1 4 3 0 0 2 00000000 1 0 00000000
D 1 5 3 4 0 2 00000000 0 3 00000000
B 3 0000abcd
D 1 6 4 0 1 0 0000abcd 1 0 00000000
B 2 00001234
R 2 3 00001234
R 3 4 0000abcd
D 1 7 3 4 1 0 00001234 1 0 0000abcd
# two writers of x8, rd equal to rs sees the older tag
D 1 8 0 0 1 0 00000000 1 0 00000000
D 1 8 8 0 0 7 00000000 1 0 00000000
B 4 00000044
B 5 00000055
B 6 00000066
B 7 00000077
R 4 5 00000044
R 5 6 00000055
R 6 7 00000066
R 7 8 00000077
D 1 9 8 0 0 8 00000000 1 0 00000000
B 8 00000088
R 8 8 00000088
I
D 1 10 8 9 1 0 00000088 0 9 00000000
B 9 00000099
B 10 000000aa
R 9 9 00000099
R 10 10 000000aa
# fill all 32 tags with wrap, then one dropped dispatch
D 32 11 0 0 1 0 00000000 1 0 00000000
D 1 12 11 0 0 10 00000000 1 0 00000000
B 11 000000bb
R 11 11 000000bb
D 1 13 0 0 1 0 00000000 1 0 00000000

/* rename_core.f */
hdl/rename_pkg.sv
hdl/rat_arf.sv
hdl/reorder_buffer.sv
hdl/operand_lookup.sv
hdl/rename_core.sv
tb/rename_core_chk.sv
tb/rename_core_tb.sv
